// File: project.f
logic/axis_out_pkg.sv
logic/cdc_sync.sv
logic/dual_clock_ram.sv
logic/async_fifo.sv
logic/axis_out_regs.sv
logic/axis_out_ctrl.sv
logic/axis_out_top.sv
tb/axis_out_tb.sv

// File: Bender.yml
package:
  name: axis_out

sources:
  - logic/axis_out_pkg.sv
  - logic/cdc_sync.sv
  - logic/dual_clock_ram.sv
  - logic/async_fifo.sv
  - logic/axis_out_regs.sv
  - logic/axis_out_ctrl.sv
  - logic/axis_out_top.sv
  - target: test
    files:
      - tb/axis_out_tb.sv

// File: tb/axis_out_tb.sv
`timescale 1ns/10ps

module axis_out_tb
   import axis_out_pkg::*;
();

   typedef enum logic [1:0] {
      K_STREAM,
      K_FULL,
      K_DISABLE,
      K_SOFTRST
   } kind_t;

   // one row of the stimulus table
   typedef struct packed {
      kind_t              kind;
      logic               mode;
      logic [DATA_W-1:0]  nwords;
      logic [7:0]         nwrite;
      logic               backpressure;
      logic [LEVEL_W-1:0] threshold;
   } case_t;

   logic              clk_i;
   logic              axis_clk_i;
   logic              rst_n_i;
   csr_req_t          csr_req_i;
   logic [DATA_W-1:0] csr_rdata_o;
   logic              data_wready_o;
   logic              interrupt_o;
   logic              sys_tvalid_i;
   logic [DATA_W-1:0] sys_tdata_i;
   logic              sys_tready_o;
   logic              axis_tvalid_o;
   axis_beat_t        axis_beat_o;
   logic              axis_tready_i;

   case_t      cases [6];
   axis_beat_t got_q [$];
   axis_beat_t exp_q [$];
   int         beat_no;
   logic [1:0] ready_mode;
   logic       ready_pat [256];
   logic [7:0] pat_idx;
   logic       hold_on;
   logic       held_valid;
   axis_beat_t held_beat;

   axis_out_top uut (
      .clk_i        (clk_i),
      .axis_clk_i   (axis_clk_i),
      .rst_n_i      (rst_n_i),
      .csr_req_i    (csr_req_i),
      .csr_rdata_o  (csr_rdata_o),
      .data_wready_o(data_wready_o),
      .interrupt_o  (interrupt_o),
      .sys_tvalid_i (sys_tvalid_i),
      .sys_tdata_i  (sys_tdata_i),
      .sys_tready_o (sys_tready_o),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_beat_o  (axis_beat_o),
      .axis_tready_i(axis_tready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // stream clock lags clk_i by 1 ns
   initial begin
      axis_clk_i = 1'b0;
      #1;
      forever #2 axis_clk_i = ~axis_clk_i;
   end

   // drive tready, then record the beat that transfers at the next rising edge
   always @(negedge axis_clk_i) begin
      case (ready_mode)
         2'd0: axis_tready_i = 1'b0;
         2'd1: axis_tready_i = 1'b1;
         default: begin
            axis_tready_i = ready_pat[pat_idx];
            pat_idx++;
         end
      endcase
      if (hold_on && held_valid) begin
         check_flag("axis_tvalid_o", axis_tvalid_o, 1'b1);
         check_beat("axis_beat_o", axis_beat_o, held_beat);
      end
      if (axis_tvalid_o === 1'b1 && axis_tready_i) begin
         got_q.push_back(axis_beat_o);
      end
      held_valid = hold_on && (axis_tvalid_o === 1'b1) && !axis_tready_i;
      held_beat  = axis_beat_o;
   end

   task automatic stop_with_failure();
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s got tdata=%02h tlast=%0b, expected tdata=%02h tlast=%0b",
                  $time, name, got.tdata, got.tlast, exp.tdata, exp.tlast);
         stop_with_failure();
      end
   endtask

   task automatic check_status(input string name, input fifo_status_t got,
                               input fifo_status_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s got empty=%0b full=%0b level=%0d, expected %0b %0b %0d",
                  $time, name, got.empty, got.full, got.level, exp.empty, exp.full, exp.level);
         stop_with_failure();
      end
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s got %0h, expected %0h", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s got %0b, expected %0b", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   function automatic fifo_status_t make_status(logic empty, logic full, int level);
      fifo_status_t st;
      st.empty = empty;
      st.full  = full;
      st.level = LEVEL_W'(level);
      return st;
   endfunction

   task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      csr_req_i.valid = 1'b1;
      csr_req_i.we    = 1'b1;
      csr_req_i.addr  = addr;
      csr_req_i.wdata = data;
      @(negedge clk_i);
      csr_req_i = '0;
   endtask

   // read data is registered, so it is there one cycle later
   task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      csr_req_i.valid = 1'b1;
      csr_req_i.we    = 1'b0;
      csr_req_i.addr  = addr;
      csr_req_i.wdata = '0;
      @(negedge clk_i);
      csr_req_i = '0;
      data = csr_rdata_o;
   endtask

   task automatic read_status(output fifo_status_t st);
      logic [DATA_W-1:0] rd;
      csr_read(ADDR_STATUS, rd);
      st.empty = rd[0];
      st.full  = rd[1];
      csr_read(ADDR_LEVEL, rd);
      st.level = rd[LEVEL_W-1:0];
   endtask

   task automatic write_data(input logic [DATA_W-1:0] word);
      int n;
      n = 0;
      while (!data_wready_o) begin
         @(negedge clk_i);
         n++;
         if (n > 200) begin
            $display("timeout: data_wready_o never came back high");
            stop_with_failure();
         end
      end
      csr_write(ADDR_DATA, word);
   endtask

   task automatic dma_push(input logic [DATA_W-1:0] word);
      int n;
      n = 0;
      sys_tvalid_i = 1'b1;
      sys_tdata_i  = word;
      while (!sys_tready_o) begin
         @(negedge clk_i);
         n++;
         if (n > 200) begin
            $display("timeout: sys_tready_o never went high for a DMA word");
            stop_with_failure();
         end
      end
      @(negedge clk_i);
      sys_tvalid_i = 1'b0;
   endtask

   // split lsb first and cut after beat nwords
   task automatic add_expected(input logic [DATA_W-1:0] word, input logic [DATA_W-1:0] nwords);
      axis_beat_t b;
      for (int i = 0; i < BEATS_PER_WORD; i++) begin
         beat_no++;
         if (DATA_W'(beat_no) <= nwords) begin
            b.tdata = word[i*TDATA_W +: TDATA_W];
            b.tlast = (DATA_W'(beat_no) == nwords);
            exp_q.push_back(b);
         end
      end
   endtask

   task automatic wait_beats(input int count);
      int n;
      n = 0;
      while (got_q.size() < count) begin
         @(negedge clk_i);
         n++;
         if (n > 4000) begin
            $display("timeout: only %0d of %0d beats arrived", got_q.size(), count);
            stop_with_failure();
         end
      end
   endtask

   task automatic wait_empty();
      logic [DATA_W-1:0] rd;
      int                n;
      n = 0;
      csr_read(ADDR_STATUS, rd);
      while (!rd[0]) begin
         n++;
         if (n > 100) begin
            $display("timeout: STATUS never reported the FIFO empty");
            stop_with_failure();
         end
         csr_read(ADDR_STATUS, rd);
      end
   endtask

   task automatic expect_quiet(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk_i);
         check_flag("axis_tvalid_o", axis_tvalid_o, 1'b0);
      end
   endtask

   task automatic soft_reset();
      hold_on    = 1'b0;
      ready_mode = 2'd0;
      csr_write(ADDR_ENABLE, '0);
      csr_write(ADDR_SOFT_RESET, 32'd1);
      repeat (8) @(negedge clk_i);
      csr_write(ADDR_SOFT_RESET, '0);
      // let both pointer synchronizers settle on zero
      repeat (8) @(negedge clk_i);
      got_q.delete();
   endtask

   task automatic configure(input case_t row);
      soft_reset();
      csr_write(ADDR_MODE, DATA_W'(row.mode));
      csr_write(ADDR_NWORDS, row.nwords);
      csr_write(ADDR_THRESHOLD, DATA_W'(row.threshold));
      exp_q.delete();
      beat_no = 0;
   endtask

   task automatic finish_stream();
      fifo_status_t st;
      wait_beats(exp_q.size());
      expect_quiet(24);
      check_word("beat count", got_q.size(), exp_q.size());
      foreach (exp_q[i]) begin
         check_beat($sformatf("axis_beat_o[%0d]", i), got_q[i], exp_q[i]);
      end
      wait_empty();
      read_status(st);
      check_status("STATUS/LEVEL", st, make_status(1'b1, 1'b0, 0));
   endtask

   task automatic run_stream(input case_t row);
      logic [DATA_W-1:0] w;
      ready_mode = row.backpressure ? 2'd2 : 2'd1;
      hold_on    = 1'b1;
      csr_write(ADDR_ENABLE, 32'd1);
      for (int i = 0; i < int'(row.nwrite); i++) begin
         w = $urandom();
         add_expected(w, row.nwords);
         if (row.mode) begin
            dma_push(w);
         end else begin
            write_data(w);
         end
      end
      finish_stream();
   endtask

   task automatic run_full(input case_t row);
      logic [DATA_W-1:0] w;
      fifo_status_t      st;
      hold_on = 1'b1;
      check_flag("interrupt_o", interrupt_o, 1'b1);
      csr_write(ADDR_ENABLE, 32'd1);
      for (int i = 1; i <= int'(row.nwrite); i++) begin
         w = $urandom();
         add_expected(w, row.nwords);
         write_data(w);
         // only one beat is popped, so the level equals the words written
         check_flag("interrupt_o", interrupt_o, i <= int'(row.threshold));
      end
      check_flag("data_wready_o", data_wready_o, 1'b0);
      read_status(st);
      check_status("STATUS/LEVEL", st, make_status(1'b0, 1'b1, int'(row.nwrite)));
      // this word is lost
      csr_write(ADDR_DATA, $urandom());
      read_status(st);
      check_status("STATUS/LEVEL", st, make_status(1'b0, 1'b1, int'(row.nwrite)));
      ready_mode = 2'd1;
      finish_stream();
      check_flag("interrupt_o", interrupt_o, 1'b1);
   endtask

   task automatic run_disable(input case_t row);
      logic [DATA_W-1:0] rd;
      ready_mode = 2'd1;
      for (int i = 0; i < int'(row.nwrite); i++) begin
         write_data($urandom());
      end
      expect_quiet(24);
      csr_read(ADDR_LEVEL, rd);
      check_word("LEVEL", rd, '0);
      // dma mode still needs the enable
      csr_write(ADDR_MODE, 32'd1);
      check_flag("sys_tready_o", sys_tready_o, 1'b0);
      check_word("beat count", got_q.size(), '0);
   endtask

   task automatic run_soft_reset(input case_t row);
      logic [DATA_W-1:0] rd;
      fifo_status_t      st;
      csr_write(ADDR_ENABLE, 32'd1);
      for (int i = 0; i < int'(row.nwrite); i++) begin
         write_data($urandom());
      end
      csr_read(ADDR_LEVEL, rd);
      check_word("LEVEL", rd, DATA_W'(row.nwrite));
      soft_reset();
      read_status(st);
      check_status("STATUS/LEVEL", st, make_status(1'b1, 1'b0, 0));
      csr_write(ADDR_ENABLE, 32'd1);
      ready_mode = 2'd1;
      expect_quiet(32);
      check_word("beat count", got_q.size(), '0);
   endtask

   initial begin
      case_t row;
      void'($urandom(32'hce5b1f70));
      rst_n_i       = 1'b0;
      csr_req_i     = '0;
      sys_tvalid_i  = 1'b0;
      sys_tdata_i   = '0;
      axis_tready_i = 1'b0;
      ready_mode    = 2'd0;
      pat_idx       = '0;
      hold_on       = 1'b0;
      held_valid    = 1'b0;
      held_beat     = '0;
      beat_no       = 0;
      // tready high about two cycles in three
      for (int i = 0; i < 256; i++) begin
         ready_pat[i] = ($urandom_range(2, 0) != 0);
      end

      // kind, mode, nwords, words, back-pressure, threshold
      cases[0] = '{K_STREAM,  1'b0, 32'd12, 8'd3,  1'b0, LEVEL_W'(0)};
      cases[1] = '{K_STREAM,  1'b0, 32'd9,  8'd3,  1'b0, LEVEL_W'(0)};
      cases[2] = '{K_STREAM,  1'b1, 32'd32, 8'd8,  1'b1, LEVEL_W'(0)};
      cases[3] = '{K_FULL,    1'b0, 32'd64, 8'd16, 1'b0, LEVEL_W'(4)};
      cases[4] = '{K_DISABLE, 1'b0, 32'd12, 8'd3,  1'b0, LEVEL_W'(0)};
      cases[5] = '{K_SOFTRST, 1'b0, 32'd64, 8'd3,  1'b0, LEVEL_W'(0)};

      repeat (10) @(negedge clk_i);
      rst_n_i = 1'b1;
      repeat (6) @(negedge clk_i);

      check_flag("axis_tvalid_o", axis_tvalid_o, 1'b0);
      check_flag("sys_tready_o", sys_tready_o, 1'b0);
      check_word("csr_rdata_o", csr_rdata_o, '0);
      check_flag("data_wready_o", data_wready_o, 1'b1);
      check_flag("interrupt_o", interrupt_o, 1'b1);

      for (int c = 0; c < 6; c++) begin
         row = cases[c];
         $display("case %0d: kind %0d, nwords %0d", c, row.kind, row.nwords);
         configure(row);
         case (row.kind)
            K_STREAM:  run_stream(row);
            K_FULL:    run_full(row);
            K_DISABLE: run_disable(row);
            default:   run_soft_reset(row);
         endcase
      end

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: logic/axis_out_top.sv
`timescale 1ns/10ps

module axis_out_top
   import axis_out_pkg::*;
(
   input  logic              clk_i,
   input  logic              axis_clk_i,
   input  logic              rst_n_i,
   input  csr_req_t          csr_req_i,
   output logic [DATA_W-1:0] csr_rdata_o,
   output logic              data_wready_o,
   output logic              interrupt_o,
   input  logic              sys_tvalid_i,
   input  logic [DATA_W-1:0] sys_tdata_i,
   output logic              sys_tready_o,
   output logic              axis_tvalid_o,
   output axis_beat_t        axis_beat_o,
   input  logic              axis_tready_i
);

   csr_cfg_t           cfg;
   fifo_status_t       fifo_status;
   logic               fifo_wen;
   logic [DATA_W-1:0]  fifo_wdata;
   logic               axis_rst_n;
   logic               axis_soft_rst;
   logic               axis_enable;
   logic [DATA_W-1:0]  axis_nwords;
   logic               axis_fifo_ren;
   logic               axis_fifo_empty;
   logic [TDATA_W-1:0] axis_fifo_data;

   axis_out_regs regs (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .csr_req_i    (csr_req_i),
      .fifo_status_i(fifo_status),
      .sys_tvalid_i (sys_tvalid_i),
      .sys_tdata_i  (sys_tdata_i),
      .cfg_o        (cfg),
      .fifo_wen_o   (fifo_wen),
      .fifo_wdata_o (fifo_wdata),
      .sys_tready_o (sys_tready_o),
      .data_wready_o(data_wready_o),
      .csr_rdata_o  (csr_rdata_o),
      .interrupt_o  (interrupt_o)
   );

   // reset into the stream domain, flushed while rst_n_i is held low
   cdc_sync #(.payload_t(logic)) rst_sync (
      .clk_i  (axis_clk_i),
      .rst_n_i(1'b1),
      .data_i (rst_n_i),
      .data_o (axis_rst_n)
   );

   cdc_sync #(.payload_t(logic)) soft_rst_sync (
      .clk_i  (axis_clk_i),
      .rst_n_i(axis_rst_n),
      .data_i (cfg.soft_reset),
      .data_o (axis_soft_rst)
   );

   cdc_sync #(.payload_t(logic)) enable_sync (
      .clk_i  (axis_clk_i),
      .rst_n_i(axis_rst_n),
      .data_i (cfg.enable),
      .data_o (axis_enable)
   );

   // nwords is static once enable is set
   cdc_sync #(.payload_t(logic [DATA_W-1:0])) nwords_sync (
      .clk_i  (axis_clk_i),
      .rst_n_i(axis_rst_n),
      .data_i (cfg.nwords),
      .data_o (axis_nwords)
   );

   async_fifo fifo (
      .w_clk_i     (clk_i),
      .w_rst_n_i   (rst_n_i),
      .w_soft_rst_i(cfg.soft_reset),
      .w_en_i      (fifo_wen),
      .w_data_i    (fifo_wdata),
      .status_o    (fifo_status),
      .r_clk_i     (axis_clk_i),
      .r_rst_n_i   (axis_rst_n),
      .r_soft_rst_i(axis_soft_rst),
      .r_en_i      (axis_fifo_ren),
      .r_data_o    (axis_fifo_data),
      .r_empty_o   (axis_fifo_empty)
   );

   axis_out_ctrl ctrl (
      .axis_clk_i   (axis_clk_i),
      .rst_n_i      (axis_rst_n),
      .soft_rst_i   (axis_soft_rst),
      .enable_i     (axis_enable),
      .nwords_i     (axis_nwords),
      .fifo_empty_i (axis_fifo_empty),
      .fifo_data_i  (axis_fifo_data),
      .fifo_ren_o   (axis_fifo_ren),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_beat_o  (axis_beat_o),
      .axis_tready_i(axis_tready_i)
   );

endmodule

// File: logic/axis_out_ctrl.sv
`timescale 1ns/10ps

module axis_out_ctrl
   import axis_out_pkg::*;
(
   input  logic               axis_clk_i,
   input  logic               rst_n_i,
   input  logic               soft_rst_i,
   input  logic               enable_i,
   input  logic [DATA_W-1:0]  nwords_i,
   input  logic               fifo_empty_i,
   input  logic [TDATA_W-1:0] fifo_data_i,
   output logic               fifo_ren_o,
   output logic               axis_tvalid_o,
   output axis_beat_t         axis_beat_o,
   input  logic               axis_tready_i
);

   typedef enum logic {
      ST_IDLE,
      ST_PRESENT
   } state_t;

   state_t            state;
   state_t            state_nxt;
   logic              pop;
   logic [DATA_W-1:0] beat_cnt;

   always_comb begin
      state_nxt     = state;
      pop           = 1'b0;
      axis_tvalid_o = 1'b0;
      case (state)
         ST_IDLE: begin
            if (!fifo_empty_i) begin
               pop       = 1'b1;
               state_nxt = ST_PRESENT;
            end
         end
         default: begin
            if (beat_cnt <= nwords_i) begin
               axis_tvalid_o = enable_i;
               if (axis_tready_i) begin
                  if (fifo_empty_i) begin
                     state_nxt = ST_IDLE;
                  end else begin
                     pop = 1'b1;
                  end
               end
            end else if (fifo_empty_i) begin
               state_nxt = ST_IDLE;
            end else begin
               // padding beat, dropped without tvalid
               pop = 1'b1;
            end
         end
      endcase
   end

   assign fifo_ren_o        = pop & enable_i;
   assign axis_beat_o.tdata = fifo_data_i;
   assign axis_beat_o.tlast = (beat_cnt == nwords_i) & axis_tvalid_o;

   // counter only clears on reset, one packet per soft reset
   always_ff @(posedge axis_clk_i) begin
      if (!rst_n_i || soft_rst_i) begin
         state    <= ST_IDLE;
         beat_cnt <= '0;
      end else if (enable_i) begin
         state <= state_nxt;
         if (fifo_ren_o) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

endmodule

// File: logic/axis_out_regs.sv
`timescale 1ns/10ps

module axis_out_regs
   import axis_out_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  csr_req_t          csr_req_i,
   input  fifo_status_t      fifo_status_i,
   input  logic              sys_tvalid_i,
   input  logic [DATA_W-1:0] sys_tdata_i,
   output csr_cfg_t          cfg_o,
   output logic              fifo_wen_o,
   output logic [DATA_W-1:0] fifo_wdata_o,
   output logic              sys_tready_o,
   output logic              data_wready_o,
   output logic [DATA_W-1:0] csr_rdata_o,
   output logic              interrupt_o
);

   logic csr_wr;
   logic csr_rd;
   logic data_wr;
   logic cpu_push;
   logic dma_push;

   assign csr_wr  = csr_req_i.valid & csr_req_i.we;
   assign csr_rd  = csr_req_i.valid & ~csr_req_i.we;
   assign data_wr = csr_wr & (csr_req_i.addr == ADDR_DATA);

   // configuration writes
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cfg_o <= '0;
      end else if (csr_wr) begin
         case (csr_req_i.addr)
            ADDR_SOFT_RESET: cfg_o.soft_reset <= csr_req_i.wdata[0];
            ADDR_ENABLE:     cfg_o.enable     <= csr_req_i.wdata[0];
            ADDR_MODE:       cfg_o.mode       <= csr_req_i.wdata[0];
            ADDR_NWORDS:     cfg_o.nwords     <= csr_req_i.wdata;
            ADDR_THRESHOLD:  cfg_o.threshold  <= csr_req_i.wdata[LEVEL_W-1:0];
            default: ;
         endcase
      end
   end

   // ready levels towards cpu and dma source
   assign data_wready_o = ~fifo_status_i.full;
   assign sys_tready_o  = ~fifo_status_i.full & cfg_o.enable & cfg_o.mode;

   // fifo push from whichever source the mode selects
   assign cpu_push     = data_wr & ~cfg_o.mode & data_wready_o;
   assign dma_push     = sys_tvalid_i & sys_tready_o;
   assign fifo_wen_o   = cfg_o.enable & (cpu_push | dma_push);
   assign fifo_wdata_o = sys_tvalid_i ? sys_tdata_i : csr_req_i.wdata;

   assign interrupt_o = (fifo_status_i.level <= cfg_o.threshold);

   // status reads, one cycle latency
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         csr_rdata_o <= '0;
      end else begin
         csr_rdata_o <= '0;
         if (csr_rd) begin
            case (csr_req_i.addr)
               ADDR_STATUS: begin
                  csr_rdata_o[0] <= fifo_status_i.empty;
                  csr_rdata_o[1] <= fifo_status_i.full;
               end
               ADDR_LEVEL: begin
                  csr_rdata_o <= DATA_W'(fifo_status_i.level);
               end
               default: ;
            endcase
         end
      end
   end

endmodule

// File: logic/async_fifo.sv
`timescale 1ns/10ps

module async_fifo
   import axis_out_pkg::*;
(
   input  logic               w_clk_i,
   input  logic               w_rst_n_i,
   input  logic               w_soft_rst_i,
   input  logic               w_en_i,
   input  logic [DATA_W-1:0]  w_data_i,
   output fifo_status_t       status_o,
   input  logic               r_clk_i,
   input  logic               r_rst_n_i,
   input  logic               r_soft_rst_i,
   input  logic               r_en_i,
   output logic [TDATA_W-1:0] r_data_o,
   output logic               r_empty_o
);

   // write pointer counts words, read pointer counts beats
   typedef logic [RAM_ADDR_W:0]  wptr_t;
   typedef logic [FIFO_ADDR_W:0] rptr_t;

   function automatic rptr_t gray_to_bin(rptr_t gray);
      rptr_t bin;
      bin[FIFO_ADDR_W] = gray[FIFO_ADDR_W];
      for (int i = FIFO_ADDR_W - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // write side
   wptr_t              w_ptr;
   wptr_t              w_ptr_nxt;
   wptr_t              w_ptr_gray;
   rptr_t              r_ptr_gray_w;
   rptr_t              r_ptr_bin_w;
   wptr_t              r_word_w;
   logic [LEVEL_W-1:0] w_level;
   logic               w_push;

   // read side
   rptr_t                                  r_ptr;
   rptr_t                                  r_ptr_nxt;
   rptr_t                                  r_ptr_gray;
   wptr_t                                  w_ptr_gray_r;
   rptr_t                                  w_ptr_bin_r;
   logic                                   r_pop;
   logic [LANE_W-1:0]                      r_lane_q;
   logic [BEATS_PER_WORD-1:0]              r_lane_en;
   logic [BEATS_PER_WORD-1:0][TDATA_W-1:0] r_lane_data;

   assign w_ptr_nxt   = w_ptr + 1'b1;
   assign r_ptr_bin_w = gray_to_bin(r_ptr_gray_w);
   // a word stays occupied until its last beat is popped
   assign r_word_w    = r_ptr_bin_w[FIFO_ADDR_W:LANE_W];
   assign w_level     = w_ptr - r_word_w;

   assign status_o.level = w_level;
   assign status_o.empty = (w_level == '0);
   assign status_o.full  = (w_level == LEVEL_W'(2**RAM_ADDR_W));

   assign w_push = w_en_i & ~status_o.full;

   always_ff @(posedge w_clk_i) begin
      if (!w_rst_n_i || w_soft_rst_i) begin
         w_ptr      <= '0;
         w_ptr_gray <= '0;
      end else if (w_push) begin
         w_ptr      <= w_ptr_nxt;
         w_ptr_gray <= w_ptr_nxt ^ (w_ptr_nxt >> 1);
      end
   end

   cdc_sync #(
      .payload_t(rptr_t)
   ) r_ptr_sync (
      .clk_i  (w_clk_i),
      .rst_n_i(w_rst_n_i),
      .data_i (r_ptr_gray),
      .data_o (r_ptr_gray_w)
   );

   cdc_sync #(
      .payload_t(wptr_t)
   ) w_ptr_sync (
      .clk_i  (r_clk_i),
      .rst_n_i(r_rst_n_i),
      .data_i (w_ptr_gray),
      .data_o (w_ptr_gray_r)
   );

   // widening keeps the gray value since the top bits are zero
   assign w_ptr_bin_r = gray_to_bin(rptr_t'(w_ptr_gray_r));
   assign r_empty_o   = (r_ptr == {w_ptr_bin_r[RAM_ADDR_W:0], {LANE_W{1'b0}}});
   assign r_pop       = r_en_i & ~r_empty_o;
   assign r_ptr_nxt   = r_ptr + 1'b1;

   always_ff @(posedge r_clk_i) begin
      if (!r_rst_n_i || r_soft_rst_i) begin
         r_ptr      <= '0;
         r_ptr_gray <= '0;
      end else if (r_pop) begin
         r_ptr      <= r_ptr_nxt;
         r_ptr_gray <= r_ptr_nxt ^ (r_ptr_nxt >> 1);
      end
   end

   // lane of the beat being read, for the output mux
   always_ff @(posedge r_clk_i) begin
      if (!r_rst_n_i) begin
         r_lane_q <= '0;
      end else if (r_pop) begin
         r_lane_q <= r_ptr[LANE_W-1:0];
      end
   end

   // one byte ram per lane, lsb lane first
   for (genvar p = 0; p < BEATS_PER_WORD; p++) begin : gen_lane
      assign r_lane_en[p] = r_pop & (r_ptr[LANE_W-1:0] == LANE_W'(p));

      dual_clock_ram lane_ram (
         .w_clk_i (w_clk_i),
         .w_en_i  (w_push),
         .w_addr_i(w_ptr[RAM_ADDR_W-1:0]),
         .w_data_i(w_data_i[p*TDATA_W +: TDATA_W]),
         .r_clk_i (r_clk_i),
         .r_en_i  (r_lane_en[p]),
         .r_addr_i(r_ptr[FIFO_ADDR_W-1:LANE_W]),
         .r_data_o(r_lane_data[p])
      );
   end

   assign r_data_o = r_lane_data[r_lane_q];

endmodule

// File: logic/dual_clock_ram.sv
`timescale 1ns/10ps

module dual_clock_ram
   import axis_out_pkg::*;
(
   input  logic                  w_clk_i,
   input  logic                  w_en_i,
   input  logic [RAM_ADDR_W-1:0] w_addr_i,
   input  logic [TDATA_W-1:0]    w_data_i,
   input  logic                  r_clk_i,
   input  logic                  r_en_i,
   input  logic [RAM_ADDR_W-1:0] r_addr_i,
   output logic [TDATA_W-1:0]    r_data_o
);

   logic [TDATA_W-1:0] mem [2**RAM_ADDR_W];

   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read data holds between reads
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

// File: logic/cdc_sync.sv
`timescale 1ns/10ps

module cdc_sync #(
   parameter type payload_t = logic
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  payload_t data_i,
   output payload_t data_o
);

   // first stage may go metastable
   payload_t meta_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         meta_q <= '0;
         data_o <= '0;
      end else begin
         meta_q <= data_i;
         data_o <= meta_q;
      end
   end

endmodule

// File: logic/axis_out_pkg.sv
package axis_out_pkg;

   // word and beat widths
   localparam int DATA_W         = 32;
   localparam int TDATA_W        = 8;
   localparam int BEATS_PER_WORD = DATA_W / TDATA_W;
   localparam int LANE_W         = $clog2(BEATS_PER_WORD);

   // fifo geometry, capacity counted in beats
   localparam int FIFO_ADDR_W = 6;
   localparam int RAM_ADDR_W  = FIFO_ADDR_W - LANE_W;
   localparam int LEVEL_W     = FIFO_ADDR_W - 1;

   // register map
   localparam int CSR_ADDR_W = 4;

   localparam logic [CSR_ADDR_W-1:0] ADDR_SOFT_RESET = 4'h0;
   localparam logic [CSR_ADDR_W-1:0] ADDR_ENABLE     = 4'h1;
   localparam logic [CSR_ADDR_W-1:0] ADDR_DATA       = 4'h2;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MODE       = 4'h3;
   localparam logic [CSR_ADDR_W-1:0] ADDR_NWORDS     = 4'h4;
   localparam logic [CSR_ADDR_W-1:0] ADDR_THRESHOLD  = 4'h5;
   localparam logic [CSR_ADDR_W-1:0] ADDR_STATUS     = 4'h6;
   localparam logic [CSR_ADDR_W-1:0] ADDR_LEVEL      = 4'h7;

   // one cpu bus cycle
   typedef struct packed {
      logic                  valid;
      logic                  we;
      logic [CSR_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     wdata;
   } csr_req_t;

   // configuration registers, mode 0 is cpu and 1 is dma
   typedef struct packed {
      logic               soft_reset;
      logic               enable;
      logic               mode;
      logic [DATA_W-1:0]  nwords;
      logic [LEVEL_W-1:0] threshold;
   } csr_cfg_t;

   // write side view of the fifo, level in words
   typedef struct packed {
      logic               empty;
      logic               full;
      logic [LEVEL_W-1:0] level;
   } fifo_status_t;

   typedef struct packed {
      logic [TDATA_W-1:0] tdata;
      logic               tlast;
   } axis_beat_t;

endpackage
